// ==== hdl/axil_pkg.sv ====
package axil_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Target window, WIN_BASE <= addr < WIN_END
    localparam logic [ADDR_W-1:0] WIN_BASE = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] WIN_END  = 32'h4001_0000;

    // Only data word the target will take on a write
    localparam logic [DATA_W-1:0] MATCH_DATA = 32'h0000_FFFF;

    // AXI response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_e;

    // Arbiter states, one whole transaction per grant
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WRITE,
        ARB_READ
    } arb_state_e;

    // Write address channel
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_aw_t;

    // Write data channel
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axil_w_t;

    // Write response channel
    typedef struct packed {
        resp_e resp;
    } axil_b_t;

    // Read address channel
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_ar_t;

    // Read data channel
    typedef struct packed {
        logic [DATA_W-1:0] data;
        resp_e             resp;
    } axil_r_t;

endpackage

// ==== hdl/axil_arbiter.sv ====
`timescale 1ns/100ps

module axil_arbiter (
    input  logic               seq,
    input  logic               rst,

    // Manager 0
    input  axil_pkg::axil_aw_t m0_aw,
    input  logic               m0_aw_valid,
    output logic               m0_aw_ready,
    input  axil_pkg::axil_w_t  m0_w,
    input  logic               m0_w_valid,
    output logic               m0_w_ready,
    output axil_pkg::axil_b_t  m0_b,
    output logic               m0_b_valid,
    input  logic               m0_b_ready,
    input  axil_pkg::axil_ar_t m0_ar,
    input  logic               m0_ar_valid,
    output logic               m0_ar_ready,
    output axil_pkg::axil_r_t  m0_r,
    output logic               m0_r_valid,
    input  logic               m0_r_ready,

    // Manager 1
    input  axil_pkg::axil_aw_t m1_aw,
    input  logic               m1_aw_valid,
    output logic               m1_aw_ready,
    input  axil_pkg::axil_w_t  m1_w,
    input  logic               m1_w_valid,
    output logic               m1_w_ready,
    output axil_pkg::axil_b_t  m1_b,
    output logic               m1_b_valid,
    input  logic               m1_b_ready,
    input  axil_pkg::axil_ar_t m1_ar,
    input  logic               m1_ar_valid,
    output logic               m1_ar_ready,
    output axil_pkg::axil_r_t  m1_r,
    output logic               m1_r_valid,
    input  logic               m1_r_ready,

    // Target port
    output axil_pkg::axil_aw_t t_aw,
    output logic               t_aw_valid,
    input  logic               t_aw_ready,
    output axil_pkg::axil_w_t  t_w,
    output logic               t_w_valid,
    input  logic               t_w_ready,
    input  axil_pkg::axil_b_t  t_b,
    input  logic               t_b_valid,
    output logic               t_b_ready,
    output axil_pkg::axil_ar_t t_ar,
    output logic               t_ar_valid,
    input  logic               t_ar_ready,
    input  axil_pkg::axil_r_t  t_r,
    input  logic               t_r_valid,
    output logic               t_r_ready
);

    axil_pkg::arb_state_e state;
    logic                 gnt;
    logic [1:0]           ptr;

    logic [3:0]           req;
    logic [1:0]           pick;
    logic                 pick_found;
    logic                 wr_gnt;
    logic                 rd_gnt;

    // Request slots in rotation order: m0 write, m0 read, m1 write, m1 read
    assign req[0] = m0_aw_valid && m0_w_valid;
    assign req[1] = m0_ar_valid;
    assign req[2] = m1_aw_valid && m1_w_valid;
    assign req[3] = m1_ar_valid;

    // First pending slot at or after the pointer
    always_comb begin
        logic [1:0] idx;
        pick       = ptr;
        pick_found = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            idx = ptr + 2'(i);
            if (req[idx]) begin
                pick       = idx;
                pick_found = 1'b1;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            state <= axil_pkg::ARB_IDLE;
            gnt   <= 1'b0;
            ptr   <= 2'd0;
        end else begin
            case (state)
                axil_pkg::ARB_IDLE: begin
                    if (pick_found) begin
                        // pick[1] selects the manager, pick[0] the direction
                        state <= pick[0] ? axil_pkg::ARB_READ : axil_pkg::ARB_WRITE;
                        gnt   <= pick[1];
                        ptr   <= pick + 2'd1;
                    end
                end
                axil_pkg::ARB_WRITE: begin
                    if (t_b_valid && t_b_ready) begin
                        state <= axil_pkg::ARB_IDLE;
                    end
                end
                axil_pkg::ARB_READ: begin
                    if (t_r_valid && t_r_ready) begin
                        state <= axil_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= axil_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    assign wr_gnt = (state == axil_pkg::ARB_WRITE);
    assign rd_gnt = (state == axil_pkg::ARB_READ);

    // Granted manager onto the target
    assign t_aw       = gnt ? m1_aw : m0_aw;
    assign t_w        = gnt ? m1_w : m0_w;
    assign t_ar       = gnt ? m1_ar : m0_ar;
    assign t_aw_valid = wr_gnt && (gnt ? m1_aw_valid : m0_aw_valid);
    assign t_w_valid  = wr_gnt && (gnt ? m1_w_valid : m0_w_valid);
    assign t_ar_valid = rd_gnt && (gnt ? m1_ar_valid : m0_ar_valid);
    assign t_b_ready  = wr_gnt && (gnt ? m1_b_ready : m0_b_ready);
    assign t_r_ready  = rd_gnt && (gnt ? m1_r_ready : m0_r_ready);

    // Readies only reach the owner of the grant
    assign m0_aw_ready = wr_gnt && !gnt && t_aw_ready;
    assign m0_w_ready  = wr_gnt && !gnt && t_w_ready;
    assign m0_ar_ready = rd_gnt && !gnt && t_ar_ready;
    assign m1_aw_ready = wr_gnt && gnt && t_aw_ready;
    assign m1_w_ready  = wr_gnt && gnt && t_w_ready;
    assign m1_ar_ready = rd_gnt && gnt && t_ar_ready;

    // Response payload is shared, the valid picks the owner
    assign m0_b       = t_b;
    assign m1_b       = t_b;
    assign m0_r       = t_r;
    assign m1_r       = t_r;
    assign m0_b_valid = wr_gnt && !gnt && t_b_valid;
    assign m1_b_valid = wr_gnt && gnt && t_b_valid;
    assign m0_r_valid = rd_gnt && !gnt && t_r_valid;
    assign m1_r_valid = rd_gnt && gnt && t_r_valid;

endmodule

// ==== hdl/axil_window_target.sv ====
`timescale 1ns/100ps

module axil_window_target (
    input  logic               seq,
    input  logic               rst,

    input  axil_pkg::axil_aw_t aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  axil_pkg::axil_w_t  w,
    input  logic               w_valid,
    output logic               w_ready,
    output axil_pkg::axil_b_t  b,
    output logic               b_valid,
    input  logic               b_ready,

    input  axil_pkg::axil_ar_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output axil_pkg::axil_r_t  r,
    output logic               r_valid,
    input  logic               r_ready
);

    logic            wr_accept;
    logic            rd_accept;
    logic            wr_in_win;
    logic            rd_in_win;
    axil_pkg::resp_e wr_resp;

    function automatic logic in_window(input logic [axil_pkg::ADDR_W-1:0] addr);
        return (addr >= axil_pkg::WIN_BASE) && (addr < axil_pkg::WIN_END);
    endfunction

    // AW and W are taken in the same cycle, never one alone
    assign aw_ready  = aw_valid && w_valid && !b_valid;
    assign w_ready   = aw_ready;
    assign wr_accept = aw_valid && aw_ready;

    assign ar_ready  = ar_valid && !r_valid;
    assign rd_accept = ar_valid && ar_ready;

    assign wr_in_win = in_window(aw.addr);
    assign rd_in_win = in_window(ar.addr);

    // Decode error wins over a strobe error
    always_comb begin
        if (!wr_in_win || (w.data != axil_pkg::MATCH_DATA)) begin
            wr_resp = axil_pkg::RESP_DECERR;
        end else if (w.strb != {axil_pkg::STRB_W{1'b1}}) begin
            wr_resp = axil_pkg::RESP_SLVERR;
        end else begin
            wr_resp = axil_pkg::RESP_OKAY;
        end
    end

    // Write response
    always_ff @(posedge seq) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else if (wr_accept) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (wr_accept) begin
            b.resp <= wr_resp;
        end
    end

    // Read response
    always_ff @(posedge seq) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (rd_accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (rd_accept) begin
            if (rd_in_win) begin
                r.data <= axil_pkg::MATCH_DATA;
                r.resp <= axil_pkg::RESP_OKAY;
            end else begin
                r.data <= '0;
                r.resp <= axil_pkg::RESP_DECERR;
            end
        end
    end

endmodule

// ==== hdl/axil_check_top.sv ====
`timescale 1ns/100ps

module axil_check_top (
    input  logic               seq,
    input  logic               rst,

    input  axil_pkg::axil_aw_t m0_aw,
    input  logic               m0_aw_valid,
    output logic               m0_aw_ready,
    input  axil_pkg::axil_w_t  m0_w,
    input  logic               m0_w_valid,
    output logic               m0_w_ready,
    output axil_pkg::axil_b_t  m0_b,
    output logic               m0_b_valid,
    input  logic               m0_b_ready,
    input  axil_pkg::axil_ar_t m0_ar,
    input  logic               m0_ar_valid,
    output logic               m0_ar_ready,
    output axil_pkg::axil_r_t  m0_r,
    output logic               m0_r_valid,
    input  logic               m0_r_ready,

    input  axil_pkg::axil_aw_t m1_aw,
    input  logic               m1_aw_valid,
    output logic               m1_aw_ready,
    input  axil_pkg::axil_w_t  m1_w,
    input  logic               m1_w_valid,
    output logic               m1_w_ready,
    output axil_pkg::axil_b_t  m1_b,
    output logic               m1_b_valid,
    input  logic               m1_b_ready,
    input  axil_pkg::axil_ar_t m1_ar,
    input  logic               m1_ar_valid,
    output logic               m1_ar_ready,
    output axil_pkg::axil_r_t  m1_r,
    output logic               m1_r_valid,
    input  logic               m1_r_ready
);

    // Shared target port
    axil_pkg::axil_aw_t t_aw;
    axil_pkg::axil_w_t  t_w;
    axil_pkg::axil_b_t  t_b;
    axil_pkg::axil_ar_t t_ar;
    axil_pkg::axil_r_t  t_r;
    logic               t_aw_valid;
    logic               t_aw_ready;
    logic               t_w_valid;
    logic               t_w_ready;
    logic               t_b_valid;
    logic               t_b_ready;
    logic               t_ar_valid;
    logic               t_ar_ready;
    logic               t_r_valid;
    logic               t_r_ready;

    axil_arbiter u_arbiter (
        .seq         (seq),
        .rst         (rst),
        .m0_aw       (m0_aw),
        .m0_aw_valid (m0_aw_valid),
        .m0_aw_ready (m0_aw_ready),
        .m0_w        (m0_w),
        .m0_w_valid  (m0_w_valid),
        .m0_w_ready  (m0_w_ready),
        .m0_b        (m0_b),
        .m0_b_valid  (m0_b_valid),
        .m0_b_ready  (m0_b_ready),
        .m0_ar       (m0_ar),
        .m0_ar_valid (m0_ar_valid),
        .m0_ar_ready (m0_ar_ready),
        .m0_r        (m0_r),
        .m0_r_valid  (m0_r_valid),
        .m0_r_ready  (m0_r_ready),
        .m1_aw       (m1_aw),
        .m1_aw_valid (m1_aw_valid),
        .m1_aw_ready (m1_aw_ready),
        .m1_w        (m1_w),
        .m1_w_valid  (m1_w_valid),
        .m1_w_ready  (m1_w_ready),
        .m1_b        (m1_b),
        .m1_b_valid  (m1_b_valid),
        .m1_b_ready  (m1_b_ready),
        .m1_ar       (m1_ar),
        .m1_ar_valid (m1_ar_valid),
        .m1_ar_ready (m1_ar_ready),
        .m1_r        (m1_r),
        .m1_r_valid  (m1_r_valid),
        .m1_r_ready  (m1_r_ready),
        .t_aw        (t_aw),
        .t_aw_valid  (t_aw_valid),
        .t_aw_ready  (t_aw_ready),
        .t_w         (t_w),
        .t_w_valid   (t_w_valid),
        .t_w_ready   (t_w_ready),
        .t_b         (t_b),
        .t_b_valid   (t_b_valid),
        .t_b_ready   (t_b_ready),
        .t_ar        (t_ar),
        .t_ar_valid  (t_ar_valid),
        .t_ar_ready  (t_ar_ready),
        .t_r         (t_r),
        .t_r_valid   (t_r_valid),
        .t_r_ready   (t_r_ready)
    );

    axil_window_target u_target (
        .seq      (seq),
        .rst      (rst),
        .aw       (t_aw),
        .aw_valid (t_aw_valid),
        .aw_ready (t_aw_ready),
        .w        (t_w),
        .w_valid  (t_w_valid),
        .w_ready  (t_w_ready),
        .b        (t_b),
        .b_valid  (t_b_valid),
        .b_ready  (t_b_ready),
        .ar       (t_ar),
        .ar_valid (t_ar_valid),
        .ar_ready (t_ar_ready),
        .r        (t_r),
        .r_valid  (t_r_valid),
        .r_ready  (t_r_ready)
    );

endmodule

// ==== sim/axil_check_assert.sv ====
`timescale 1ns/100ps

module axil_check_assert (
    input logic              seq,
    input logic              rst,
    input axil_pkg::axil_b_t m0_b,
    input logic              m0_b_valid,
    input logic              m0_b_ready,
    input axil_pkg::axil_r_t m0_r,
    input logic              m0_r_valid,
    input logic              m0_r_ready,
    input axil_pkg::axil_b_t m1_b,
    input logic              m1_b_valid,
    input logic              m1_b_ready,
    input axil_pkg::axil_r_t m1_r,
    input logic              m1_r_valid,
    input logic              m1_r_ready
);

    // Stalled responses keep valid and payload
    m0_b_hold: assert property (@(posedge seq) disable iff (rst)
        m0_b_valid && !m0_b_ready |=> m0_b_valid && $stable(m0_b))
        else $error("m0 write response changed while stalled");
    m0_r_hold: assert property (@(posedge seq) disable iff (rst)
        m0_r_valid && !m0_r_ready |=> m0_r_valid && $stable(m0_r))
        else $error("m0 read response changed while stalled");
    m1_b_hold: assert property (@(posedge seq) disable iff (rst)
        m1_b_valid && !m1_b_ready |=> m1_b_valid && $stable(m1_b))
        else $error("m1 write response changed while stalled");
    m1_r_hold: assert property (@(posedge seq) disable iff (rst)
        m1_r_valid && !m1_r_ready |=> m1_r_valid && $stable(m1_r))
        else $error("m1 read response changed while stalled");

    // One owner per response channel
    b_owner: assert property (@(posedge seq) disable iff (rst) !(m0_b_valid && m1_b_valid))
        else $error("both managers see b_valid");
    r_owner: assert property (@(posedge seq) disable iff (rst) !(m0_r_valid && m1_r_valid))
        else $error("both managers see r_valid");

    reset_idle: assert property (@(posedge seq)
        rst |=> !(m0_b_valid || m0_r_valid || m1_b_valid || m1_r_valid))
        else $error("response valid high right after reset");

endmodule

bind axil_check_top axil_check_assert u_assert (.*);

// ==== sim/axil_check_tb.sv ====
`timescale 1ns/100ps

module axil_check_tb;

    // 4 + 5 + 2 + 2 + 4 directed transactions plus 60 random ones
    localparam int NUM_TXN    = 77;
    localparam int MAX_CYCLES = 40 * NUM_TXN;

    logic seq;
    logic rst;

    // Manager ports indexed by manager number
    axil_pkg::axil_aw_t aw [2];
    axil_pkg::axil_w_t  w [2];
    axil_pkg::axil_b_t  b [2];
    axil_pkg::axil_ar_t ar [2];
    axil_pkg::axil_r_t  r [2];
    logic aw_valid [2];
    logic aw_ready [2];
    logic w_valid [2];
    logic w_ready [2];
    logic b_valid [2];
    logic b_ready [2];
    logic ar_valid [2];
    logic ar_ready [2];
    logic r_valid [2];
    logic r_ready [2];

    logic [31:0] lfsr;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;

    axil_check_top DUT (
        .seq         (seq),
        .rst         (rst),
        .m0_aw       (aw[0]),
        .m0_aw_valid (aw_valid[0]),
        .m0_aw_ready (aw_ready[0]),
        .m0_w        (w[0]),
        .m0_w_valid  (w_valid[0]),
        .m0_w_ready  (w_ready[0]),
        .m0_b        (b[0]),
        .m0_b_valid  (b_valid[0]),
        .m0_b_ready  (b_ready[0]),
        .m0_ar       (ar[0]),
        .m0_ar_valid (ar_valid[0]),
        .m0_ar_ready (ar_ready[0]),
        .m0_r        (r[0]),
        .m0_r_valid  (r_valid[0]),
        .m0_r_ready  (r_ready[0]),
        .m1_aw       (aw[1]),
        .m1_aw_valid (aw_valid[1]),
        .m1_aw_ready (aw_ready[1]),
        .m1_w        (w[1]),
        .m1_w_valid  (w_valid[1]),
        .m1_w_ready  (w_ready[1]),
        .m1_b        (b[1]),
        .m1_b_valid  (b_valid[1]),
        .m1_b_ready  (b_ready[1]),
        .m1_ar       (ar[1]),
        .m1_ar_valid (ar_valid[1]),
        .m1_ar_ready (ar_ready[1]),
        .m1_r        (r[1]),
        .m1_r_valid  (r_valid[1]),
        .m1_r_ready  (r_ready[1])
    );

    always #10 seq = ~seq;

    always @(posedge seq) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: a transaction did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hA300_0000;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Expected responses straight from the window, pattern and strobe rules
    function automatic axil_pkg::axil_b_t exp_b(input logic [31:0] addr,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        axil_pkg::axil_b_t e;
        if (addr < axil_pkg::WIN_BASE || addr >= axil_pkg::WIN_END ||
            data != axil_pkg::MATCH_DATA) begin
            e.resp = axil_pkg::RESP_DECERR;
        end else if (strb != 4'hF) begin
            e.resp = axil_pkg::RESP_SLVERR;
        end else begin
            e.resp = axil_pkg::RESP_OKAY;
        end
        return e;
    endfunction

    function automatic axil_pkg::axil_r_t exp_r(input logic [31:0] addr);
        axil_pkg::axil_r_t e;
        if (addr < axil_pkg::WIN_BASE || addr >= axil_pkg::WIN_END) begin
            e.data = '0;
            e.resp = axil_pkg::RESP_DECERR;
        end else begin
            e.data = axil_pkg::MATCH_DATA;
            e.resp = axil_pkg::RESP_OKAY;
        end
        return e;
    endfunction

    task automatic init_manager(input logic mgr);
        aw[mgr]       = '0;
        w[mgr]        = '0;
        ar[mgr]       = '0;
        aw_valid[mgr] = 1'b0;
        w_valid[mgr]  = 1'b0;
        ar_valid[mgr] = 1'b0;
        b_ready[mgr]  = 1'b0;
        r_ready[mgr]  = 1'b0;
    endtask

    task automatic check_b(input logic mgr, input logic [31:0] addr,
                           input axil_pkg::axil_b_t exp, input axil_pkg::axil_b_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: m%0d_b.resp at addr %h: expected %h, got %h",
                     mgr, addr, exp.resp, got.resp);
        end
    endtask

    task automatic check_r(input logic mgr, input logic [31:0] addr,
                           input axil_pkg::axil_r_t exp, input axil_pkg::axil_r_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: m%0d_r at addr %h: expected data %h resp %h, got data %h resp %h",
                     mgr, addr, exp.data, exp.resp, got.data, got.resp);
        end
    endtask

    // Request, then hold b_ready low for hold cycles once B is valid
    task automatic do_write(input logic mgr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold,
                            output axil_pkg::axil_b_t resp);
        aw[mgr].addr  = addr;
        w[mgr].data   = data;
        w[mgr].strb   = strb;
        aw_valid[mgr] = 1'b1;
        w_valid[mgr]  = 1'b1;
        @(negedge seq);
        while (!(aw_ready[mgr] && w_ready[mgr])) @(negedge seq);
        @(posedge seq);
        #2;
        aw_valid[mgr] = 1'b0;
        w_valid[mgr]  = 1'b0;
        @(negedge seq);
        while (!b_valid[mgr]) @(negedge seq);
        resp = b[mgr];
        repeat (hold) @(negedge seq);
        @(posedge seq);
        #2;
        if (!b_valid[mgr] || b[mgr] !== resp) begin
            errors++;
            $display("Manager %0d write response changed or dropped while b_ready was low", mgr);
        end
        b_ready[mgr] = 1'b1;
        @(posedge seq);
        #2;
        b_ready[mgr] = 1'b0;
    endtask

    task automatic do_read(input logic mgr, input logic [31:0] addr, input int hold,
                           output axil_pkg::axil_r_t resp);
        ar[mgr].addr  = addr;
        ar_valid[mgr] = 1'b1;
        @(negedge seq);
        while (!ar_ready[mgr]) @(negedge seq);
        @(posedge seq);
        #2;
        ar_valid[mgr] = 1'b0;
        @(negedge seq);
        while (!r_valid[mgr]) @(negedge seq);
        resp = r[mgr];
        repeat (hold) @(negedge seq);
        @(posedge seq);
        #2;
        if (!r_valid[mgr] || r[mgr] !== resp) begin
            errors++;
            $display("Manager %0d read response changed or dropped while r_ready was low", mgr);
        end
        r_ready[mgr] = 1'b1;
        @(posedge seq);
        #2;
        r_ready[mgr] = 1'b0;
    endtask

    task automatic write_check(input logic mgr, input logic [31:0] addr,
                               input logic [31:0] data, input logic [3:0] strb, input int hold);
        axil_pkg::axil_b_t got;
        do_write(mgr, addr, data, strb, hold, got);
        check_b(mgr, addr, exp_b(addr, data, strb), got);
    endtask

    task automatic read_check(input logic mgr, input logic [31:0] addr, input int hold);
        axil_pkg::axil_r_t got;
        do_read(mgr, addr, hold, got);
        check_r(mgr, addr, exp_r(addr), got);
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        $display("%-16s %s (%0d errors)", name, (errors == e0) ? "ok" : "fail", errors - e0);
    endtask

    task automatic test_window_ok();
        int e0;
        e0 = errors;
        write_check(1'b0, axil_pkg::WIN_BASE, axil_pkg::MATCH_DATA, 4'hF, 0);
        write_check(1'b0, axil_pkg::WIN_END - 32'd4, axil_pkg::MATCH_DATA, 4'hF, 0);
        read_check(1'b0, axil_pkg::WIN_BASE, 0);
        read_check(1'b0, axil_pkg::WIN_END - 32'd4, 0);
        report("window_ok", e0);
    endtask

    task automatic test_decode_err();
        int e0;
        e0 = errors;
        write_check(1'b0, axil_pkg::WIN_END, axil_pkg::MATCH_DATA, 4'hF, 0);
        write_check(1'b0, axil_pkg::WIN_BASE - 32'd4, axil_pkg::MATCH_DATA, 4'hF, 0);
        write_check(1'b1, axil_pkg::WIN_BASE + 32'h8, 32'h1234_5678, 4'hF, 0);
        read_check(1'b0, axil_pkg::WIN_END, 0);
        read_check(1'b1, axil_pkg::WIN_BASE - 32'd4, 0);
        report("decode_err", e0);
    endtask

    task automatic test_strobe_err();
        int e0;
        e0 = errors;
        write_check(1'b0, axil_pkg::WIN_BASE + 32'h4, axil_pkg::MATCH_DATA, 4'h7, 0);
        write_check(1'b1, axil_pkg::WIN_BASE + 32'h100, axil_pkg::MATCH_DATA, 4'hE, 0);
        report("strobe_err", e0);
    endtask

    task automatic test_concurrent();
        int e0;
        e0 = errors;
        fork
            write_check(1'b0, axil_pkg::WIN_BASE + 32'h10, axil_pkg::MATCH_DATA, 4'hF, 0);
            read_check(1'b1, axil_pkg::WIN_END, 0);
        join
        report("concurrent", e0);
    endtask

    // The stalled manager holds the grant, so the other one must finish later
    task automatic stall_pair(input logic stall_mgr, input logic stall_is_read);
        time t_stall;
        time t_other;
        fork
            begin
                if (stall_is_read) begin
                    read_check(stall_mgr, axil_pkg::WIN_BASE + 32'h20, 6);
                end else begin
                    write_check(stall_mgr, axil_pkg::WIN_BASE + 32'h20,
                                axil_pkg::MATCH_DATA, 4'hF, 6);
                end
                t_stall = $time;
            end
            begin
                @(posedge seq);
                #2;
                if (stall_is_read) begin
                    write_check(!stall_mgr, axil_pkg::WIN_END - 32'd8, axil_pkg::MATCH_DATA,
                                4'hF, 0);
                end else begin
                    read_check(!stall_mgr, axil_pkg::WIN_END - 32'd8, 0);
                end
                t_other = $time;
            end
        join
        if (t_other <= t_stall) begin
            errors++;
            $display("Manager %0d finished before the stalled response was accepted", !stall_mgr);
        end
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = errors;
        stall_pair(1'b0, 1'b0);
        stall_pair(1'b1, 1'b1);
        report("backpressure", e0);
    endtask

    task automatic test_random();
        int          e0;
        logic        mgr;
        logic        is_read;
        logic [1:0]  region;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        int          hold;
        e0 = errors;
        for (int n = 0; n < 60; n++) begin
            mgr     = 1'(rand_bits(1));
            is_read = 1'(rand_bits(1));
            region  = 2'(rand_bits(2));
            case (region)
                2'd0:    addr = axil_pkg::WIN_BASE - 32'd16 + (rand_bits(3) << 2);
                2'd1:    addr = axil_pkg::WIN_END - 32'd16 + (rand_bits(3) << 2);
                default: addr = rand_bits(32);
            endcase
            data = (rand_bits(1) == 32'd1) ? axil_pkg::MATCH_DATA : rand_bits(32);
            strb = (rand_bits(1) == 32'd1) ? 4'hF : 4'(rand_bits(4));
            hold = int'(rand_bits(2));
            if (is_read) begin
                read_check(mgr, addr, hold);
            end else begin
                write_check(mgr, addr, data, strb, hold);
            end
        end
        report("random", e0);
    endtask

    initial begin
        seq  = 1'b0;
        rst  = 1'b1;
        lfsr = 32'h5ab3_7f1d;
        init_manager(1'b0);
        init_manager(1'b1);
        repeat (3) @(posedge seq);
        #2;
        rst = 1'b0;

        test_window_ok();
        test_decode_err();
        test_strobe_err();
        test_concurrent();
        test_backpressure();
        test_random();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hdl/axil_pkg.sv
hdl/axil_arbiter.sv
hdl/axil_window_target.sv
hdl/axil_check_top.sv
sim/axil_check_assert.sv
sim/axil_check_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module axil_check_tb -o axil_check_sim

./obj_dir/axil_check_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log
